//--- common/muldiv_cfg.svh
/*
 Multiply/divide unit configuration
 Operand, partial register and adder widths, and the step counts
 of the iterative multiply and divide
*/
`ifndef MULDIV_CFG_SVH
`define MULDIV_CFG_SVH

// Operand and result word
`define MULDIV_XLEN 32
// Partial registers carry one sign bit above the word
`define MULDIV_PART_W 33
// Shared adder, room for a Booth x2 term plus sign
`define MULDIV_ADDER_W 35
// Divide steps only use the low 34 bits of the adder
`define MULDIV_DIV_OPND_W 34

// Iterations after the first step
`define MULDIV_MUL_STEPS 16
`define MULDIV_DIV_STEPS 32
`define MULDIV_CNT_W 6

`endif

//--- common/muldiv_pkg.sv
/*
 Multiply/divide unit boundary types
 Request word as issued by the core and the result word written back
*/
`include "muldiv_cfg.svh"

package muldiv_pkg;

  // Operand or result word
  typedef logic [`MULDIV_XLEN-1:0] xlen_t;

  // M extension ops, in funct3 order
  // Bit 2 set means a divide op
  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    DIV    = 3'd4,
    DIVU   = 3'd5,
    REM    = 3'd6,
    REMU   = 3'd7
  } muldiv_op_e;

  // Request held on the inputs while i_valid is high
  typedef struct packed {
    muldiv_op_e op;
    xlen_t      rs1;
    xlen_t      rs2;
  } muldiv_req_t;

endpackage

//--- common/muldiv_dp_pkg.sv
/*
 Multiply/divide datapath and control types
 Partial registers, shared adder request and the per-cycle
 step control sent from the FSM to the datapath
*/
`include "muldiv_cfg.svh"

package muldiv_dp_pkg;

  // Hi/remainder and lo/quotient registers
  typedef logic [`MULDIV_PART_W-1:0] part_t;

  // Shared adder operand and sum
  typedef logic [`MULDIV_ADDER_W-1:0] adder_t;

  typedef enum logic [2:0] {
    FIRST     = 3'd0,
    EXEC      = 3'd1,
    REMD_CHCK = 3'd2,
    QUOT_CORR = 3'd3,
    REMD_CORR = 3'd4
  } muldiv_state_e;

  // Adder computes op1 + op2, or op1 - op2 when sub is set
  typedef struct packed {
    adder_t op1;
    adder_t op2;
    logic   sub;
  } adder_req_t;

  typedef struct packed {
    muldiv_state_e state;
    logic          first_cycle;
    logic          step_en;
    logic          last_step;
  } step_ctl_t;

endpackage

//--- muldiv_dp/booth_mul_path.sv
/*
 Radix-4 Booth multiply step
 Recodes three multiplier bits per step into 0, +-1 or +-2 times the
 multiplicand, and shifts the product two bits per step
*/
`include "muldiv_cfg.svh"

module booth_mul_path (
  input  muldiv_pkg::muldiv_req_t   i_req,
  input  muldiv_dp_pkg::step_ctl_t  i_step,
  input  muldiv_dp_pkg::part_t      i_hi,
  input  muldiv_dp_pkg::part_t      i_lo,
  input  logic                      i_sft,
  input  muldiv_dp_pkg::adder_t     i_sum,
  output muldiv_dp_pkg::adder_req_t o_adder,
  output muldiv_dp_pkg::part_t      o_hi_nxt,
  output muldiv_dp_pkg::part_t      o_lo_nxt,
  output logic                      o_sft_nxt,
  output muldiv_pkg::xlen_t         o_res
);

  logic rs1_sign;
  logic rs2_sign;
  logic [2:0] booth_code;
  logic sel_zero;
  logic sel_two;
  muldiv_dp_pkg::adder_t mcand_x1;
  muldiv_dp_pkg::adder_t mcand_x2;

  // MUL is taken as signed x signed, low word is the same
  assign rs1_sign = (i_req.op == muldiv_pkg::MULHU) ? 1'b0 : i_req.rs1[`MULDIV_XLEN-1];
  assign rs2_sign = (i_req.op == muldiv_pkg::MULHSU || i_req.op == muldiv_pkg::MULHU)
                  ? 1'b0 : i_req.rs2[`MULDIV_XLEN-1];

  // Last step sees the extended sign in place of product bits
  assign booth_code = i_step.first_cycle ? {i_req.rs1[1:0], 1'b0}
                    : i_step.last_step   ? {rs1_sign, i_lo[0], i_sft}
                    :                      {i_lo[1:0], i_sft};

  // 000/111 -> 0, 011 -> +2, 100 -> -2, others +-1
  assign sel_zero = (booth_code == 3'b000) || (booth_code == 3'b111);
  assign sel_two  = (booth_code == 3'b011) || (booth_code == 3'b100);

  assign mcand_x1 = {{3{rs2_sign}}, i_req.rs2};
  assign mcand_x2 = {{2{rs2_sign}}, i_req.rs2, 1'b0};

  assign o_adder.op1 = i_step.first_cycle ? '0
                     : {{2{i_hi[`MULDIV_PART_W-1]}}, i_hi};
  assign o_adder.op2 = sel_zero ? '0 : (sel_two ? mcand_x2 : mcand_x1);
  assign o_adder.sub = booth_code[2];

  // Two product bits drop into lo, multiplier bits move down
  assign o_hi_nxt  = i_sum[`MULDIV_ADDER_W-1:2];
  assign o_lo_nxt  = {i_sum[1:0],
                      i_step.first_cycle ? {rs1_sign, i_req.rs1[`MULDIV_XLEN-1:2]}
                                         : i_lo[`MULDIV_PART_W-1:2]};
  assign o_sft_nxt = i_step.first_cycle ? i_req.rs1[1] : i_lo[1];

  // High word comes straight off the final add
  assign o_res = (i_req.op == muldiv_pkg::MUL) ? i_lo[`MULDIV_PART_W-1:1]
                                               : i_sum[`MULDIV_XLEN-1:0];

endmodule

//--- muldiv_dp/nonrestore_div_path.sv
/*
 Non-restoring divide step
 One quotient bit per step, then a remainder check and optional
 quotient and remainder correction. Division by zero and signed
 overflow are detected here and answered with fixed results
*/
`include "muldiv_cfg.svh"

module nonrestore_div_path (
  input  muldiv_pkg::muldiv_req_t   i_req,
  input  muldiv_dp_pkg::step_ctl_t  i_step,
  input  muldiv_dp_pkg::part_t      i_remd,
  input  muldiv_dp_pkg::part_t      i_quot,
  input  logic                      i_sft,
  input  muldiv_dp_pkg::adder_t     i_sum,
  output muldiv_dp_pkg::adder_req_t o_adder,
  output muldiv_dp_pkg::part_t      o_remd_nxt,
  output muldiv_dp_pkg::part_t      o_quot_nxt,
  output logic                      o_sft_nxt,
  output logic                      o_need_corr,
  output logic                      o_special,
  output muldiv_pkg::xlen_t         o_res
);

  logic is_div;
  logic is_signed;
  logic is_quot;
  logic s1;
  logic s2;
  logic [`MULDIV_DIV_OPND_W-1:0] divisor;
  logic [`MULDIV_DIV_OPND_W-1:0] div_sum;
  logic [`MULDIV_DIV_OPND_W-1:0] step_op1;
  logic [`MULDIV_DIV_OPND_W-1:0] add_op1;
  logic [`MULDIV_DIV_OPND_W-1:0] add_op2;
  logic add_sub;
  logic q0;
  logic prev_quot;
  logic cur_quot;
  muldiv_dp_pkg::part_t step_low;
  logic remd_neg;
  logic div_by_0;
  logic div_ovf;
  muldiv_pkg::xlen_t min_neg;
  muldiv_pkg::xlen_t special_res;
  muldiv_pkg::xlen_t res_remd;

  assign is_div    = i_req.op inside {muldiv_pkg::DIV, muldiv_pkg::DIVU,
                                      muldiv_pkg::REM, muldiv_pkg::REMU};
  assign is_signed = (i_req.op == muldiv_pkg::DIV) || (i_req.op == muldiv_pkg::REM);
  assign is_quot   = (i_req.op == muldiv_pkg::DIV) || (i_req.op == muldiv_pkg::DIVU);
  assign s1 = is_signed & i_req.rs1[`MULDIV_XLEN-1];
  assign s2 = is_signed & i_req.rs2[`MULDIV_XLEN-1];

  assign divisor = {s2, s2, i_req.rs2};
  assign div_sum = i_sum[`MULDIV_DIV_OPND_W-1:0];

  //////////////////////////////////////////////////
  // Iteration
  //////////////////////////////////////////////////
  // First quotient bit is -1 when dividend and divisor signs differ
  assign q0        = ~(s1 ^ s2);
  assign prev_quot = i_step.first_cycle ? q0 : i_quot[0];
  assign cur_quot  = ~(div_sum[`MULDIV_DIV_OPND_W-1] ^ s2);

  // Remainder top plus shift bit, and the dividend bits still to come
  assign step_op1 = i_step.first_cycle ? {`MULDIV_DIV_OPND_W{s1}} : {i_sft, i_remd};
  assign step_low = i_step.first_cycle ? {i_req.rs1, q0} : i_quot;

  // Last step keeps the remainder unshifted and forces quotient bit 0 to 1
  // Remainder holds during quotient correction
  always_comb begin
    if (i_step.state == muldiv_dp_pkg::QUOT_CORR) begin
      o_remd_nxt = i_remd;
      o_quot_nxt = div_sum[`MULDIV_PART_W-1:0];
    end else if (i_step.last_step) begin
      o_remd_nxt = div_sum[`MULDIV_PART_W-1:0];
      o_quot_nxt = {step_low[`MULDIV_XLEN-1:0], 1'b1};
    end else begin
      o_remd_nxt = {div_sum[`MULDIV_XLEN-1:0], step_low[`MULDIV_PART_W-1]};
      o_quot_nxt = {step_low[`MULDIV_XLEN-1:0], cur_quot};
    end
  end
  assign o_sft_nxt = div_sum[`MULDIV_PART_W-1];

  //////////////////////////////////////////////////
  // Check and correction
  //////////////////////////////////////////////////
  // Remainder sign differs from divisor sign
  assign remd_neg = i_remd[`MULDIV_PART_W-1] ^ s2;

  always_comb begin
    add_op1 = step_op1;
    add_op2 = divisor;
    add_sub = prev_quot;
    case (i_step.state)
      muldiv_dp_pkg::REMD_CHCK: begin
        // remd + divisor is zero when remd == -divisor
        add_op1 = {i_remd[`MULDIV_PART_W-1], i_remd};
        add_sub = 1'b0;
      end
      muldiv_dp_pkg::QUOT_CORR: begin
        add_op1 = {i_quot[`MULDIV_PART_W-1], i_quot};
        add_op2 = {{(`MULDIV_DIV_OPND_W-1){1'b0}}, 1'b1};
        add_sub = remd_neg;
      end
      muldiv_dp_pkg::REMD_CORR: begin
        add_op1 = {i_remd[`MULDIV_PART_W-1], i_remd};
        add_sub = ~remd_neg;
      end
      default: begin
        add_sub = prev_quot;
      end
    endcase
  end

  assign o_adder.op1 = {1'b0, add_op1};
  assign o_adder.op2 = {1'b0, add_op2};
  assign o_adder.sub = add_sub;

  // Fix when sign is wrong and nonzero, or remainder is +-divisor
  assign o_need_corr = ((i_remd[`MULDIV_PART_W-1] ^ s1) & (|i_remd))
                     | (div_sum == '0)
                     | (i_remd == divisor[`MULDIV_PART_W-1:0]);

  //////////////////////////////////////////////////
  // Special cases and result
  //////////////////////////////////////////////////
  assign min_neg  = {1'b1, {(`MULDIV_XLEN-1){1'b0}}};
  assign div_by_0 = (i_req.rs2 == '0);
  assign div_ovf  = is_signed & (&i_req.rs2) & (i_req.rs1 == min_neg);
  assign o_special = is_div & (div_by_0 | div_ovf);

  // x/0 gives all ones and remainder x, overflow gives MIN and 0
  assign special_res = div_by_0 ? (is_quot ? '1 : i_req.rs1)
                                : (is_quot ? min_neg : '0);

  // Corrected remainder comes straight off the adder
  assign res_remd = (i_step.state == muldiv_dp_pkg::REMD_CORR) ? div_sum[`MULDIV_XLEN-1:0]
                                                               : i_remd[`MULDIV_XLEN-1:0];

  assign o_res = o_special ? special_res
               : is_quot   ? i_quot[`MULDIV_XLEN-1:0]
               :             res_remd;

endmodule

//--- muldiv_dp/muldiv_datapath.sv
/*
 Multiply/divide datapath
 Shared add/sub adder, hi/remainder and lo/quotient registers with
 their shift extension bits, and the final result select
*/
`include "muldiv_cfg.svh"

module muldiv_datapath (
  input  logic                     clk,
  input  logic                     i_reset,
  input  muldiv_pkg::muldiv_req_t  i_req,
  input  muldiv_dp_pkg::step_ctl_t i_step,
  output logic                     o_special,
  output logic                     o_need_corr,
  output muldiv_pkg::xlen_t        o_wdat
);

  muldiv_dp_pkg::part_t hi_r;
  muldiv_dp_pkg::part_t lo_r;
  muldiv_dp_pkg::part_t mul_hi_nxt;
  muldiv_dp_pkg::part_t mul_lo_nxt;
  muldiv_dp_pkg::part_t div_remd_nxt;
  muldiv_dp_pkg::part_t div_quot_nxt;
  logic sft_hi_r;
  logic sft_lo_r;
  logic mul_sft_nxt;
  logic div_sft_nxt;
  muldiv_dp_pkg::adder_req_t mul_req;
  muldiv_dp_pkg::adder_req_t div_req;
  muldiv_dp_pkg::adder_req_t add_req;
  muldiv_dp_pkg::adder_t sum;
  muldiv_pkg::xlen_t mul_res;
  muldiv_pkg::xlen_t div_res;
  logic is_div;

  assign is_div = i_req.op inside {muldiv_pkg::DIV, muldiv_pkg::DIVU,
                                   muldiv_pkg::REM, muldiv_pkg::REMU};

  //////////////////////////////////////////////////
  // Shared adder
  //////////////////////////////////////////////////
  assign add_req = is_div ? div_req : mul_req;
  // Subtract as invert plus carry in
  assign sum = add_req.op1
             + (add_req.op2 ^ {`MULDIV_ADDER_W{add_req.sub}})
             + {{(`MULDIV_ADDER_W-1){1'b0}}, add_req.sub};

  // Hi holds product high or remainder, lo holds product low or quotient
  always_ff @(posedge clk) begin
    if (i_reset) begin
      hi_r     <= '0;
      lo_r     <= '0;
      sft_hi_r <= 1'b0;
      sft_lo_r <= 1'b0;
    end else if (i_step.step_en) begin
      hi_r     <= is_div ? div_remd_nxt : mul_hi_nxt;
      lo_r     <= is_div ? div_quot_nxt : mul_lo_nxt;
      sft_hi_r <= div_sft_nxt;
      sft_lo_r <= mul_sft_nxt;
    end
  end

  booth_mul_path booth_mul_path_i (
    .i_req     (i_req),
    .i_step    (i_step),
    .i_hi      (hi_r),
    .i_lo      (lo_r),
    .i_sft     (sft_lo_r),
    .i_sum     (sum),
    .o_adder   (mul_req),
    .o_hi_nxt  (mul_hi_nxt),
    .o_lo_nxt  (mul_lo_nxt),
    .o_sft_nxt (mul_sft_nxt),
    .o_res     (mul_res)
  );

  nonrestore_div_path nonrestore_div_path_i (
    .i_req       (i_req),
    .i_step      (i_step),
    .i_remd      (hi_r),
    .i_quot      (lo_r),
    .i_sft       (sft_hi_r),
    .i_sum       (sum),
    .o_adder     (div_req),
    .o_remd_nxt  (div_remd_nxt),
    .o_quot_nxt  (div_quot_nxt),
    .o_sft_nxt   (div_sft_nxt),
    .o_need_corr (o_need_corr),
    .o_special   (o_special),
    .o_res       (div_res)
  );

  // Special result already wins inside the divide result
  assign o_wdat = is_div ? div_res : mul_res;

endmodule

//--- hw/muldiv_ctrl.sv
/*
 Multiply/divide control
 Five-state FSM and step counter. Decides when the partial registers
 step and when the result may be written back
*/
`include "muldiv_cfg.svh"

module muldiv_ctrl (
  input  logic                     clk,
  input  logic                     i_reset,
  input  logic                     i_valid,
  input  logic                     i_o_ready,
  input  logic                     i_is_div,
  input  logic                     i_special,
  input  logic                     i_need_corr,
  output muldiv_dp_pkg::step_ctl_t o_step,
  output logic                     o_wbck
);

  muldiv_dp_pkg::muldiv_state_e state_r;
  muldiv_dp_pkg::muldiv_state_e state_nxt;
  logic [`MULDIV_CNT_W-1:0] cnt_r;
  logic [`MULDIV_CNT_W-1:0] cnt_last;
  logic is_first;
  logic is_exec;
  logic is_chck;
  logic is_qcorr;
  logic is_rcorr;
  logic exec_last;
  logic hsked;

  assign is_first = (state_r == muldiv_dp_pkg::FIRST);
  assign is_exec  = (state_r == muldiv_dp_pkg::EXEC);
  assign is_chck  = (state_r == muldiv_dp_pkg::REMD_CHCK);
  assign is_qcorr = (state_r == muldiv_dp_pkg::QUOT_CORR);
  assign is_rcorr = (state_r == muldiv_dp_pkg::REMD_CORR);

  // FIRST counts as step 0, so EXEC ends at 16 or 32
  assign cnt_last  = i_is_div ? `MULDIV_CNT_W'(`MULDIV_DIV_STEPS)
                              : `MULDIV_CNT_W'(`MULDIV_MUL_STEPS);
  assign exec_last = is_exec & (cnt_r == cnt_last);

  // Special cases answer at once, without leaving FIRST
  assign o_wbck = i_special
                | (exec_last & ~i_is_div)
                | (is_chck & ~i_need_corr)
                | is_rcorr;
  assign hsked  = o_wbck & i_valid & i_o_ready;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////
  always_comb begin
    state_nxt = state_r;
    case (state_r)
      muldiv_dp_pkg::FIRST: begin
        if (i_valid && !i_special) begin
          state_nxt = muldiv_dp_pkg::EXEC;
        end
      end
      muldiv_dp_pkg::EXEC: begin
        // Multiply holds here until the result is taken
        if (exec_last && i_is_div) begin
          state_nxt = muldiv_dp_pkg::REMD_CHCK;
        end else if (exec_last && hsked) begin
          state_nxt = muldiv_dp_pkg::FIRST;
        end
      end
      muldiv_dp_pkg::REMD_CHCK: begin
        if (i_need_corr) begin
          state_nxt = muldiv_dp_pkg::QUOT_CORR;
        end else if (hsked) begin
          state_nxt = muldiv_dp_pkg::FIRST;
        end
      end
      muldiv_dp_pkg::QUOT_CORR: begin
        state_nxt = muldiv_dp_pkg::REMD_CORR;
      end
      muldiv_dp_pkg::REMD_CORR: begin
        if (hsked) begin
          state_nxt = muldiv_dp_pkg::FIRST;
        end
      end
      default: begin
        state_nxt = muldiv_dp_pkg::FIRST;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state_r <= muldiv_dp_pkg::FIRST;
      cnt_r   <= '0;
    end else begin
      state_r <= state_nxt;
      // Load 1 on entry, then count up to the last step and stop
      if (is_first && (state_nxt == muldiv_dp_pkg::EXEC)) begin
        cnt_r <= `MULDIV_CNT_W'(1);
      end else if (is_exec && !exec_last) begin
        cnt_r <= cnt_r + `MULDIV_CNT_W'(1);
      end
    end
  end

  // Registers step on start, through EXEC, and once in QUOT_CORR
  // Last multiply step is left combinational so the result stays put
  assign o_step.state       = state_r;
  assign o_step.first_cycle = is_first;
  assign o_step.last_step   = exec_last;
  assign o_step.step_en     = (is_first & i_valid & ~i_special)
                            | (is_exec & (~exec_last | i_is_div))
                            | is_qcorr;

endmodule

//--- hw/muldiv_unit.sv
/*
 Multiply/divide unit top level
 Iterative MUL/MULH/MULHSU/MULHU and DIV/DIVU/REM/REMU on one shared
 adder. Result valid and request ready are both taken from the same
 write-back condition, so request and result complete together
*/
module muldiv_unit (
  input  logic                   clk,
  input  logic                   i_reset,
  input  logic                   i_valid,
  input  muldiv_pkg::muldiv_req_t i_req,
  input  logic                   o_ready,
  output logic                   o_valid,
  output logic                   i_ready,
  output muldiv_pkg::xlen_t      o_wdat
);

  muldiv_dp_pkg::step_ctl_t step;
  logic special;
  logic need_corr;
  logic wbck;

  // Divide ops take the long path with the check and correction states
  wire is_div = i_req.op inside {muldiv_pkg::DIV, muldiv_pkg::DIVU,
                                 muldiv_pkg::REM, muldiv_pkg::REMU};

  // Both handshakes fire in the same cycle
  assign o_valid = wbck & i_valid;
  assign i_ready = wbck & o_ready;

  muldiv_ctrl muldiv_ctrl_i (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_valid     (i_valid),
    .i_o_ready   (o_ready),
    .i_is_div    (is_div),
    .i_special   (special),
    .i_need_corr (need_corr),
    .o_step      (step),
    .o_wbck      (wbck)
  );

  muldiv_datapath muldiv_datapath_i (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_req       (i_req),
    .i_step      (step),
    .o_special   (special),
    .o_need_corr (need_corr),
    .o_wdat      (o_wdat)
  );

endmodule

//--- verif/tb_clk_gen.sv
/*
 Testbench clock source
 Free-running clock, low at time zero, with a settable period
*/
module tb_clk_gen #(
  parameter int period_ns = 40
) (
  output logic o_clk
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    o_clk = 1'b0;
    // Half period high, half period low
    forever #(period_ns / 2) o_clk = ~o_clk;
  end

endmodule

//--- verif/muldiv_chk.sv
/*
 Multiply/divide handshake checker
 Concurrent assertions on the request and result handshake,
 bound into every muldiv_unit instance
*/
module muldiv_chk (
  input logic              clk,
  input logic              i_reset,
  input logic              i_valid,
  input logic              i_o_ready,
  input logic              i_o_valid,
  input logic              i_i_ready,
  input muldiv_pkg::xlen_t i_o_wdat
);

  timeunit 1ns;
  timeprecision 1ps;

  // A stalled result stays offered while the request is still held
  a_valid_held: assert property (
    @(posedge clk) disable iff (i_reset)
      (i_o_valid && !i_o_ready) ##1 i_valid |-> i_o_valid
  ) else $error("o_valid dropped before the result was taken");

  // Result held steady while the consumer stalls
  a_wdat_stable: assert property (
    @(posedge clk) disable iff (i_reset) (i_o_valid && !i_o_ready) |=> $stable(i_o_wdat)
  ) else $error("o_wdat changed under back-pressure");

  // Request is never taken without a result going out
  a_ready_needs_valid: assert property (
    @(posedge clk) disable iff (i_reset) !i_o_valid |-> !i_i_ready
  ) else $error("i_ready high while o_valid is low");

endmodule

bind muldiv_unit muldiv_chk muldiv_chk_i (
  .clk       (clk),
  .i_reset   (i_reset),
  .i_valid   (i_valid),
  .i_o_ready (o_ready),
  .i_o_valid (o_valid),
  .i_i_ready (i_ready),
  .i_o_wdat  (o_wdat)
);

//--- verif/tb_muldiv.sv
/*
 Multiply/divide unit testbench
 Plays vectors from a hex file through the DUT with random result
 back-pressure, checks results, latency and the handshake
*/
module tb_muldiv;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_vec      = 23;
  localparam int reset_cycles = 16;
  // About 40 cycles per vector, four times over for stalls
  localparam int max_cycles   = num_vec * 40 * 4 + reset_cycles;
  localparam int settle_ns    = 5;

  logic                    clk;
  logic                    i_reset;
  logic                    i_valid;
  muldiv_pkg::muldiv_req_t i_req;
  logic                    o_ready;
  logic                    o_valid;
  logic                    i_ready;
  muldiv_pkg::xlen_t       o_wdat;

  // Four words per vector as op, rs1, rs2 and expected result
  logic [31:0] vec_mem [0:num_vec*4-1];
  logic [31:0] rng_state;
  int          cycle_cnt = 0;
  int          done_cnt;

  tb_clk_gen #(.period_ns(40)) tb_clk_gen_i (.o_clk(clk));

  muldiv_unit muldiv_unit_i (
    .clk     (clk),
    .i_reset (i_reset),
    .i_valid (i_valid),
    .i_req   (i_req),
    .o_ready (o_ready),
    .o_valid (o_valid),
    .i_ready (i_ready),
    .o_wdat  (o_wdat)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic fail_run(input string why);
    $display("ERROR: %s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Consumer ready about three cycles in four
  task automatic next_ready();
    rng_state = xorshift32(rng_state);
    o_ready   = (rng_state[1:0] != 2'b00);
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  // Idle request is a MUL of zeros, never a special case
  task automatic idle_cycle();
    @(negedge clk);
    i_valid = 1'b0;
    i_req   = '0;
    next_ready();
    #settle_ns;
    check_value("o_valid", 32'(o_valid), 32'h0);
    check_value("i_ready", 32'(i_ready), 32'h0);
  endtask

  task automatic run_vector(input int v);
    muldiv_pkg::muldiv_req_t req;
    logic [31:0] exp_res;
    logic        is_div;
    logic        is_signed;
    logic        special;
    int          cyc;
    bit          seen_valid;
    bit          done;
    req.op    = muldiv_pkg::muldiv_op_e'(vec_mem[4*v][2:0]);
    req.rs1   = vec_mem[4*v+1];
    req.rs2   = vec_mem[4*v+2];
    exp_res   = vec_mem[4*v+3];
    is_div    = vec_mem[4*v][2];
    is_signed = (req.op == muldiv_pkg::DIV) || (req.op == muldiv_pkg::REM);
    // Divide by zero, or most negative value over minus one
    special   = is_div && ((req.rs2 == 32'h0)
                || (is_signed && req.rs1 == 32'h8000_0000 && req.rs2 == 32'hffff_ffff));
    cyc        = 0;
    seen_valid = 1'b0;
    done       = 1'b0;
    while (!done) begin
      @(negedge clk);
      i_valid = 1'b1;
      i_req   = req;
      next_ready();
      #settle_ns;
      cyc++;
      if (o_valid && !seen_valid) begin
        seen_valid = 1'b1;
        if (special) begin
          check_value("latency", 32'(cyc), 32'd1);
        end else if (!is_div) begin
          check_value("latency", 32'(cyc), 32'd17);
        end else if (cyc != 34 && cyc != 36) begin
          fail_run($sformatf("vector %0d: divide result came in cycle %0d, not 34 or 36",
                             v, cyc));
        end
      end
      // Every offered result must match, stalled or not
      if (o_valid) begin
        check_value("o_wdat", o_wdat, exp_res);
      end
      check_value("i_ready", 32'(i_ready), 32'(o_valid & o_ready));
      if (o_valid && o_ready) begin
        done = 1'b1;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence and run limit
  //////////////////////////////////////////////////
  initial begin
    rng_state = 32'h8ebd35e5;
    i_reset   = 1'b1;
    i_valid   = 1'b0;
    i_req     = '0;
    o_ready   = 1'b0;
    done_cnt  = 0;
    $readmemh("verif/muldiv_input.hex", vec_mem);
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    i_reset = 1'b0;
    // Nothing may come out before the first request
    repeat (4) idle_cycle();
    for (int v = 0; v < num_vec; v++) begin
      run_vector(v);
      idle_cycle();
    end
    check_value("completions", 32'(done_cnt), 32'(num_vec));
    $display("TEST RESULT: PASS");
    $finish;
  end

  // Requests the DUT actually takes, one i_ready pulse each
  always @(posedge clk) begin
    if (!i_reset && i_ready) begin
      done_cnt = done_cnt + 1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > max_cycles) begin
      fail_run($sformatf("no progress, run passed %0d cycles", max_cycles));
    end
  end

endmodule

//--- verif/muldiv_input.hex
// Columns: op, rs1, rs2, expected result
// op: 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU, 4 DIV, 5 DIVU, 6 REM, 7 REMU
0 00000007 00000006 0000002a
0 fffffffd 00000005 fffffff1
1 fffffffd 00000005 ffffffff
1 80000000 80000000 40000000
1 7fffffff ffffffff ffffffff
2 ffffffff ffffffff ffffffff
2 00000002 80000000 00000001
3 ffffffff ffffffff fffffffe
3 12345678 00000010 00000001
0 12345678 00000010 23456780
4 00000014 00000003 00000006
4 ffffffec 00000003 fffffffa
6 ffffffec 00000003 fffffffe
4 00000015 fffffff9 fffffffd
6 00000015 fffffff9 00000000
6 ffffffeb fffffff9 00000000
5 ffffffff 00000002 7fffffff
7 ffffffff 0000000a 00000005
5 80000000 ffffffff 00000000
4 00001234 00000000 ffffffff
6 00001234 00000000 00001234
4 80000000 ffffffff 80000000
6 80000000 ffffffff 00000000

//--- verilog.f
+incdir+common
common/muldiv_pkg.sv
common/muldiv_dp_pkg.sv
muldiv_dp/booth_mul_path.sv
muldiv_dp/nonrestore_div_path.sv
muldiv_dp/muldiv_datapath.sv
hw/muldiv_ctrl.sv
hw/muldiv_unit.sv
verif/tb_clk_gen.sv
verif/muldiv_chk.sv
verif/tb_muldiv.sv

//--- Makefile
# Verilator build and run of the multiply/divide testbench

VERILATOR ?= verilator
TOP       ?= tb_muldiv
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

# Exit status of the simulation binary is the test result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
